// ==== logic/mipsPkg.sv ====
package mipsPkg;

	typedef logic [31:0] word_t;

	////////////////////////////////////////
	// instruction views
	////////////////////////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rType_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iType_t;

	typedef union packed {
		rType_t r;					// opcode zero
		iType_t i;					// everything else
	} instr_u;

	////////////////////////////////////////
	// R-type function codes
	////////////////////////////////////////

	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnNor  = 6'b100111;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;
	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnSrl  = 6'b000010;
	localparam logic [5:0] fnSra  = 6'b000011;
	localparam logic [5:0] fnJr   = 6'b001000;

	////////////////////////////////////////
	// opcodes
	////////////////////////////////////////

	localparam logic [5:0] opRtype = 6'b000000;
	localparam logic [5:0] opAddi  = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opAndi  = 6'b001100;
	localparam logic [5:0] opOri   = 6'b001101;
	localparam logic [5:0] opSlti  = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opBeq   = 6'b000100;
	localparam logic [5:0] opBne   = 6'b000101;
	localparam logic [5:0] opLui   = 6'b001111;
	localparam logic [5:0] opLw    = 6'b100011;
	localparam logic [5:0] opLl    = 6'b110000;
	localparam logic [5:0] opLbu   = 6'b100100;
	localparam logic [5:0] opLhu   = 6'b100101;
	localparam logic [5:0] opSw    = 6'b101011;
	localparam logic [5:0] opSb    = 6'b101000;
	localparam logic [5:0] opSh    = 6'b101001;
	localparam logic [5:0] opSc    = 6'b111000;

endpackage

// ==== logic/laneIf.sv ====
interface laneIf
	import mipsPkg::*;
();

	logic valid;
	logic ready;
	instr_u instr;						// decoded word
	word_t rsVal;						// rs contents
	word_t rtVal;						// rt contents
	word_t result;						// alu output on the done side

	modport source (
		output valid,
		output instr,
		output rsVal,
		output rtVal,
		output result,
		input ready
	);

	modport sink (
		input valid,
		input instr,
		input rsVal,
		input rtVal,
		input result,
		output ready
	);

endinterface

// ==== logic/issueDispatch.sv ====
module issueDispatch
	import mipsPkg::*;
#(
	parameter int laneCount = 4
)
(
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input instr_u inInstr,
	input word_t inRs,
	input word_t inRt,
	laneIf.source lanes [laneCount]
);

	localparam int ptrW = $clog2(laneCount);

	logic [ptrW-1:0] ptr;					// lane taking the next instruction
	logic [laneCount-1:0] laneReady;
	logic accept;

	////////////////////////////////////////
	// steer input to lane at pointer
	////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < laneCount; g++)
		begin : gLane
			assign lanes[g].valid = inValid && (ptr == ptrW'(g));
			assign lanes[g].instr = inInstr;		// broadcast to every lane
			assign lanes[g].rsVal = inRs;
			assign lanes[g].rtVal = inRt;
			assign lanes[g].result = '0;			// not used on issue side
			assign laneReady[g] = lanes[g].ready;
		end
	endgenerate

	assign inReady = laneReady[ptr];
	assign accept = inValid && inReady;

	////////////////////////////////////////
	// round-robin pointer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			ptr <= '0;
		else if (accept)
		begin
			// wrap after the last lane
			if (ptr == ptrW'(laneCount - 1))
				ptr <= '0;
			else
				ptr <= ptr + 1'b1;
		end
	end

endmodule

// ==== logic/mipsAlu.sv ====
module mipsAlu
	import mipsPkg::*;
(
	input logic clk,
	input logic rst,
	laneIf.sink issue,
	laneIf.source done
);

	instr_u ins;
	word_t rs;
	word_t rt;
	word_t immSext;
	word_t immZext;
	word_t aluOut;
	word_t resReg;						// held result
	logic full;							// resReg holds a result
	logic accept;
	logic drain;

	assign ins = issue.instr;
	assign rs = issue.rsVal;
	assign rt = issue.rtVal;
	assign immSext = {{16{ins.i.imm[15]}}, ins.i.imm};
	assign immZext = {16'b0, ins.i.imm};

	////////////////////////////////////////
	// result function
	////////////////////////////////////////

	always_comb
	begin
		aluOut = '0;						// J-type and unknown give zero
		if (ins.r.opcode == opRtype)
		begin
			case (ins.r.funct)
				fnAdd, fnAddu: aluOut = rs + rt;
				fnSub, fnSubu: aluOut = rs - rt;
				fnAnd: aluOut = rs & rt;
				fnOr: aluOut = rs | rt;
				fnNor: aluOut = ~(rs | rt);		// bitwise
				fnSlt: aluOut = {31'b0, $signed(rs) < $signed(rt)};
				fnSltu: aluOut = {31'b0, rs < rt};
				fnSll: aluOut = rt << ins.r.shamt;
				fnSrl: aluOut = rt >> ins.r.shamt;
				fnSra: aluOut = $signed(rt) >>> ins.r.shamt;
				fnJr: aluOut = rs;
				default: aluOut = '0;
			endcase
		end
		else
		begin
			case (ins.i.opcode)
				opAddi, opAddiu: aluOut = rs + immSext;
				opAndi: aluOut = rs & immZext;
				opOri: aluOut = rs | immZext;
				opSlti: aluOut = {31'b0, $signed(rs) < $signed(immSext)};
				opSltiu: aluOut = {31'b0, rs < immSext};	// unsigned compare
				opBeq: aluOut = {31'b0, rs == rt};
				opBne: aluOut = {31'b0, rs != rt};
				opLui: aluOut = {ins.i.imm, 16'b0};
				// address calculation for every load and store
				opLw, opLl, opLbu, opLhu,
				opSw, opSb, opSh, opSc: aluOut = rs + immSext;
				default: aluOut = '0;
			endcase
		end
	end

	////////////////////////////////////////
	// one-entry output register
	////////////////////////////////////////

	assign drain = full && done.ready;
	assign issue.ready = !full || done.ready;	// free or emptying now
	assign accept = issue.valid && issue.ready;

	always_ff @(posedge clk)
	begin
		if (rst)
			full <= 1'b0;
		else if (accept)
			full <= 1'b1;
		else if (drain)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			resReg <= aluOut;
	end

	assign done.valid = full;
	assign done.result = resReg;
	assign done.instr = '0;				// only result travels onward
	assign done.rsVal = '0;
	assign done.rtVal = '0;

endmodule

// ==== logic/resultCollect.sv ====
module resultCollect
	import mipsPkg::*;
#(
	parameter int laneCount = 4
)
(
	input logic clk,
	input logic rst,
	laneIf.sink lanes [laneCount],
	output logic outValid,
	input logic outReady,
	output word_t outResult
);

	localparam int ptrW = $clog2(laneCount);

	logic [ptrW-1:0] ptr;					// lane owed the next output
	logic [laneCount-1:0] laneValid;
	word_t laneResult [laneCount];
	logic send;

	////////////////////////////////////////
	// gather lane outputs
	////////////////////////////////////////

	genvar g;
	generate
		for (g = 0; g < laneCount; g++)
		begin : gLane
			assign laneValid[g] = lanes[g].valid;
			assign laneResult[g] = lanes[g].result;
			assign lanes[g].ready = outReady && (ptr == ptrW'(g));
		end
	endgenerate

	// same rotation as dispatch keeps issue order
	assign outValid = laneValid[ptr];
	assign outResult = laneResult[ptr];
	assign send = outValid && outReady;

	////////////////////////////////////////
	// drain pointer
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			ptr <= '0;
		else if (send)
		begin
			if (ptr == ptrW'(laneCount - 1))
				ptr <= '0;
			else
				ptr <= ptr + 1'b1;
		end
	end

endmodule

// ==== logic/aluCluster.sv ====
module aluCluster
	import mipsPkg::*;
#(
	parameter int laneCount = 4
)
(
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input instr_u inInstr,
	input word_t inRs,
	input word_t inRt,
	output logic outValid,
	input logic outReady,
	output word_t outResult
);

	laneIf issueLane [laneCount] ();		// dispatch to lanes
	laneIf doneLane [laneCount] ();		// lanes to collector

	issueDispatch #(
		.laneCount(laneCount)
	) dispatch_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.inRs(inRs),
		.inRt(inRt),
		.lanes(issueLane)
	);

	genvar g;
	generate
		for (g = 0; g < laneCount; g++)
		begin : gAlu
			mipsAlu alu_i (
				.clk(clk),
				.rst(rst),
				.issue(issueLane[g]),
				.done(doneLane[g])
			);
		end
	endgenerate

	resultCollect #(
		.laneCount(laneCount)
	) collect_i (
		.clk(clk),
		.rst(rst),
		.lanes(doneLane),
		.outValid(outValid),
		.outReady(outReady),
		.outResult(outResult)
	);

endmodule

// ==== bench/aluCluster_checker.sv ====
module aluCluster_checker
	import mipsPkg::*;
(
	input logic clk,
	input logic rst,
	input logic outValid,
	input logic outReady,
	input word_t outResult
);
	timeunit 1ns;
	timeprecision 100ps;

	int assertFails = 0;				// read by the testbench for its verdict

	stallHold: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outResult))
		else
		begin
			assertFails++;
			$error("output valid or result changed while outReady was low");
		end

	resetEmpty: assert property (@(posedge clk)
		rst |=> !outValid)
		else
		begin
			assertFails++;
			$error("outValid high in the cycle after reset");
		end

	resultKnown: assert property (@(posedge clk) disable iff (rst)
		outValid |-> !$isunknown(outResult))
		else
		begin
			assertFails++;
			$error("outResult has unknown bits while outValid is high");
		end

endmodule

bind aluCluster aluCluster_checker checker_i (
	.clk(clk),
	.rst(rst),
	.outValid(outValid),
	.outReady(outReady),
	.outResult(outResult)
);

// ==== bench/aluCluster_tb.sv ====
module aluCluster_tb
	import mipsPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int laneCount = 4;
	localparam logic [12:0][5:0] rCodes = {fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnNor,
		fnSlt, fnSltu, fnSll, fnSrl, fnSra, fnJr};
	localparam logic [16:0][5:0] iCodes = {opAddi, opAddiu, opAndi, opOri, opSlti, opSltiu,
		opBeq, opBne, opLui, opLw, opLl, opLbu, opLhu, opSw, opSb, opSh, opSc};

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic inValid = 1'b0;
	logic inReady;
	instr_u inInstr = '0;
	word_t inRs = '0;
	word_t inRt = '0;
	logic outValid;
	logic outReady = 1'b0;
	word_t outResult;

	word_t expQ[$];						// expected results in issue order
	string nameQ[$];
	int sentCount = 0;
	int recvCount = 0;
	int mismatchCount = 0;
	int otherCount = 0;
	logic stallMode = 1'b0;				// random back-pressure on outReady
	logic aborted = 1'b0;
	int stretch = 0;

	aluCluster #(
		.laneCount(laneCount)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inReady(inReady),
		.inInstr(inInstr),
		.inRs(inRs),
		.inRt(inRt),
		.outValid(outValid),
		.outReady(outReady),
		.outResult(outResult)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic logic signedLess(input word_t a, input word_t b);
		return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);	// bias flips sign order
	endfunction

	function automatic word_t modelResult(input instr_u ins, input word_t rs, input word_t rt,
		output string name);
		word_t se;
		word_t ze;
		word_t r;
		logic [63:0] ext;
		logic known;
		se = ins.i.imm[15] ? {16'hffff, ins.i.imm} : {16'h0000, ins.i.imm};
		ze = {16'h0000, ins.i.imm};
		ext = {{32{rt[31]}}, rt} >> ins.r.shamt;			// sign fill for sra
		r = '0;
		known = 1'b1;
		if (ins.r.opcode == opRtype)
		begin
			case (ins.r.funct)
				fnAdd, fnAddu: r = rs + rt;
				fnSub, fnSubu: r = rs - rt;
				fnAnd: r = rs & rt;
				fnOr: r = rs | rt;
				fnNor: r = ~rs & ~rt;
				fnSlt: r = word_t'(signedLess(rs, rt));
				fnSltu: r = word_t'(rs < rt);
				fnSll: r = rt << ins.r.shamt;
				fnSrl: r = rt >> ins.r.shamt;
				fnSra: r = ext[31:0];
				fnJr: r = rs;
				default: known = 1'b0;
			endcase
			if (!known)
				name = "unknown funct";
			else if (ins.r.funct inside {fnSll, fnSrl, fnSra, fnJr})
				name = "shift/jr";
			else
				name = "rtype";
		end
		else
		begin
			case (ins.i.opcode)
				opAddi, opAddiu, opLw, opLl, opLbu, opLhu, opSw, opSb, opSh, opSc: r = rs + se;
				opAndi: r = rs & ze;
				opOri: r = rs | ze;
				opSlti: r = word_t'(signedLess(rs, se));
				opSltiu: r = word_t'(rs < se);
				opBeq: r = word_t'(rs == rt);
				opBne: r = word_t'(rs != rt);
				opLui: r = ze << 16;
				default: known = 1'b0;
			endcase
			if (!known)
				name = "unknown opcode";
			else if (ins.i.opcode inside {opBeq, opBne})
				name = "branch";
			else
				name = "itype";
		end
		return r;
	endfunction

	function automatic instr_u randomInstr();
		instr_u ins;
		int pick;
		ins = instr_u'($urandom);
		pick = int'($urandom_range(0, 99));
		if (pick < 40)
		begin
			ins.r.opcode = opRtype;
			ins.r.funct = rCodes[4'($urandom_range(0, 12))];
		end
		else if (pick < 90)
			ins.i.opcode = iCodes[5'($urandom_range(0, 16))];
		else if (pick < 95)
		begin
			ins.r.opcode = opRtype;
			ins.r.funct = {2'b11, ins.r.funct[3:0]};			// 11xxxx is undefined
		end
		else						// j/jal or an undefined 01xxxx opcode
			ins.i.opcode = pick[0] ? {5'b00001, ins.i.opcode[0]} : {2'b01, ins.i.opcode[3:0]};
		return ins;
	endfunction

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic checkResult(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			mismatchCount++;
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
			mismatchCount++;
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (expected !== actual)
		begin
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
			mismatchCount++;
		end
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst)
			stretch <= 0;
		else if (!stallMode)
			outReady <= 1'b1;
		else if (stretch == 0)
		begin
			outReady <= !outReady;
			stretch <= outReady ? int'($urandom_range(1, 8)) : int'($urandom_range(1, 4));
		end
		else
			stretch <= stretch - 1;
	end

	task automatic sendOne();
		word_t a;
		int waited;
		a = $urandom;
		inValid <= 1'b1;
		inInstr <= randomInstr();
		inRs <= a;
		inRt <= ($urandom_range(0, 3) == 0) ? a : $urandom;	// equal operands now and then
		waited = 0;
		@(posedge clk);
		while (!inReady && waited < 100)
		begin
			waited++;
			@(posedge clk);
		end
		inValid <= 1'b0;
		if (!inReady)
		begin
			$display("Timeout: inReady stayed low for 100 cycles");
			otherCount++;
			aborted = 1'b1;
		end
	endtask

	task automatic runBurst(input int count);
		for (int n = 0; n < count && !aborted; n++)
		begin
			if ($urandom_range(0, 15) == 0)
				@(posedge clk);				// idle gap
			sendOne();
		end
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (recvCount < sentCount && waited < 500)
		begin
			waited++;
			@(negedge clk);
		end
		if (recvCount < sentCount)
		begin
			$display("Timeout: results still outstanding after 500 cycles of draining");
			otherCount++;
		end
	endtask

	// scoreboard sees both handshakes at the edge
	always @(posedge clk)
	begin : monitor
		string name;
		word_t expected;
		int inFlight;
		if (!rst)
		begin
			// a full set of lanes only frees the dispatch lane while draining
			inFlight = sentCount - recvCount;
			checkBit("inReady against occupancy", (inFlight < laneCount) || outReady, inReady);
			checkBit("outValid against occupancy", inFlight > 0, outValid);
			if (inValid && inReady)
			begin
				expected = modelResult(inInstr, inRs, inRt, name);
				expQ.push_back(expected);
				nameQ.push_back(name);
				sentCount++;
			end
			if (outValid && outReady)
			begin
				recvCount++;
				if (expQ.size() == 0)
				begin
					$display("A result came out with no instruction outstanding");
					otherCount++;
				end
				else
					checkResult(nameQ.pop_front(), expQ.pop_front(), outResult);
			end
		end
	end

	initial
	begin
		void'($urandom(32'heab084ed));
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		checkBit("outValid after reset", 1'b0, outValid);
		runBurst(300);						// output always ready
		stallMode <= 1'b1;
		runBurst(600);						// random back-pressure
		stallMode <= 1'b0;
		waitDrain();
		checkCount("results received", sentCount, recvCount);
		checkCount("results left in queue", 0, expQ.size());
		$display("closing: %0d mismatches, %0d other errors, %0d assertion failures, %0d checked",
			mismatchCount, otherCount, dut_i.checker_i.assertFails, recvCount);
		if (mismatchCount == 0 && otherCount == 0 && dut_i.checker_i.assertFails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/mipsPkg.sv
logic/laneIf.sv
logic/issueDispatch.sv
logic/mipsAlu.sv
logic/resultCollect.sv
logic/aluCluster.sv
bench/aluCluster_checker.sv
bench/aluCluster_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ALU cluster testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module aluCluster_tb \
	--Mdir obj_dir \
	-f filelist.f

./obj_dir/ValuCluster_tb | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
